//--- Bender.yml
package:
  name: csc

sources:
  - common/csc_pkg.sv
  - upsample/chroma_fir.sv
  - convert/yuv_to_rgb.sv
  - rtl/csc_sequencer.sv
  - rtl/csc_top.sv
  - target: test
    files:
      - test/tb_sram.sv
      - test/tb_csc.sv

//--- all.f
common/csc_pkg.sv
upsample/chroma_fir.sv
convert/yuv_to_rgb.sv
rtl/csc_sequencer.sv
rtl/csc_top.sv
test/tb_sram.sv
test/tb_csc.sv

//--- common/csc_pkg.sv
package csc_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 18;
	localparam int PIXEL_W = 8;
	localparam int ACC_W = 32;
	localparam int PIXEL_MAX = (1 << PIXEL_W) - 1;

	localparam logic [ADDR_W-1:0] RGB_BASE = 18'd146944;

	// colour-space matrix, 16 fractional bits
	localparam int COEF_Y = 76284;
	localparam int COEF_U_G = -25624;
	localparam int COEF_V_R = 104595;
	localparam int COEF_U_B = 132251;
	localparam int COEF_V_G = -53281;
	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;
	localparam int CSC_SHIFT = 16;

	localparam int FIR_C0 = 21; // outer taps
	localparam int FIR_C1 = 52; // subtracted
	localparam int FIR_C2 = 159; // centre taps
	localparam int FIR_ROUND = 128;
	localparam int FIR_SHIFT = 8;

	localparam int SLOT_CYCLES = 6; // cycles per pixel pair

	typedef union packed {
		logic [WORD_W-1:0] raw;
		logic [1:0][PIXEL_W-1:0] bytes; // [1] holds the earlier sample
	} sram_word_u;

	function automatic logic [PIXEL_W-1:0] clip_pixel(input logic signed [ACC_W-1:0] value);
		if (value < 0) begin
			return '0;
		end
		if (value > PIXEL_MAX) begin
			return '1;
		end
		return value[PIXEL_W-1:0];
	endfunction

endpackage

//--- convert/yuv_to_rgb.sv
`timescale 1ns/10ps

module yuv_to_rgb (
	input logic Clock_50,
	input logic Resetn,
	input logic pair_valid,
	input csc_pkg::sram_word_u y_pair,
	input logic [csc_pkg::PIXEL_W-1:0] u_even,
	input logic [csc_pkg::PIXEL_W-1:0] u_odd,
	input logic [csc_pkg::PIXEL_W-1:0] v_even,
	input logic [csc_pkg::PIXEL_W-1:0] v_odd,
	output logic [csc_pkg::PIXEL_W-1:0] r_even, g_even, b_even,
	output logic [csc_pkg::PIXEL_W-1:0] r_odd, g_odd, b_odd
);
	import csc_pkg::*;

	logic [PIXEL_W-1:0] y_in [2];
	logic [PIXEL_W-1:0] u_in [2];
	logic [PIXEL_W-1:0] v_in [2];
	logic signed [ACC_W-1:0] y_term [2];
	logic signed [ACC_W-1:0] vr_term [2];
	logic signed [ACC_W-1:0] ug_term [2];
	logic signed [ACC_W-1:0] vg_term [2];
	logic signed [ACC_W-1:0] ub_term [2];
	logic [PIXEL_W-1:0] r_px [2];
	logic [PIXEL_W-1:0] g_px [2];
	logic [PIXEL_W-1:0] b_px [2];
	logic s1_valid;

	// index 0 is the even pixel
	assign y_in[0] = y_pair.bytes[1];
	assign y_in[1] = y_pair.bytes[0];
	assign u_in[0] = u_even;
	assign u_in[1] = u_odd;
	assign v_in[0] = v_even;
	assign v_in[1] = v_odd;

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pair_valid;
		end
	end

	always_ff @(posedge Clock_50) begin
		if (pair_valid) begin
			for (int i = 0; i < 2; i++) begin
				y_term[i] <= COEF_Y * ($signed(ACC_W'(y_in[i])) - Y_OFFSET);
				vr_term[i] <= COEF_V_R * ($signed(ACC_W'(v_in[i])) - C_OFFSET);
				ug_term[i] <= COEF_U_G * ($signed(ACC_W'(u_in[i])) - C_OFFSET);
				vg_term[i] <= COEF_V_G * ($signed(ACC_W'(v_in[i])) - C_OFFSET);
				ub_term[i] <= COEF_U_B * ($signed(ACC_W'(u_in[i])) - C_OFFSET);
			end
		end
		if (s1_valid) begin
			for (int i = 0; i < 2; i++) begin
				r_px[i] <= clip_pixel((y_term[i] + vr_term[i]) >>> CSC_SHIFT);
				g_px[i] <= clip_pixel((y_term[i] + ug_term[i] + vg_term[i]) >>> CSC_SHIFT);
				b_px[i] <= clip_pixel((y_term[i] + ub_term[i]) >>> CSC_SHIFT);
			end
		end
	end

	assign r_even = r_px[0];
	assign g_even = g_px[0];
	assign b_even = b_px[0];
	assign r_odd = r_px[1];
	assign g_odd = g_px[1];
	assign b_odd = b_px[1];

	// products registered for a pair carry no unknown bits
	assert property (@(posedge Clock_50) disable iff (!Resetn)
		pair_valid |=> !$isunknown({y_term[0], y_term[1], vr_term[0], vr_term[1],
		ug_term[0], ug_term[1], vg_term[0], vg_term[1], ub_term[0], ub_term[1]}))
		else $error("stage 1 products unknown after pair_valid");

endmodule

//--- rtl/csc_sequencer.sv
`timescale 1ns/10ps

module csc_sequencer #(
	parameter int IMAGE_WIDTH = 320,
	parameter int IMAGE_HEIGHT = 240
) (
	input logic Clock_50,
	input logic Resetn,
	input logic start,
	input csc_pkg::sram_word_u sram_read_data,
	input logic [csc_pkg::PIXEL_W-1:0] r_even, g_even, b_even,
	input logic [csc_pkg::PIXEL_W-1:0] r_odd, g_odd, b_odd,
	output logic finish,
	output logic [csc_pkg::ADDR_W-1:0] sram_address,
	output logic sram_we_n,
	output csc_pkg::sram_word_u sram_write_data,
	output logic [csc_pkg::PIXEL_W-1:0] u_sample, v_sample,
	output logic u_fill, u_shift, v_fill, v_shift,
	output logic pair_valid,
	output csc_pkg::sram_word_u y_pair
);
	import csc_pkg::*;

	localparam logic [ADDR_W-1:0] HALF_W = ADDR_W'(IMAGE_WIDTH / 2);
	localparam logic [ADDR_W-1:0] LAST_PAIR = ADDR_W'(IMAGE_WIDTH / 2 - 1);
	localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(IMAGE_HEIGHT - 1);
	localparam logic [ADDR_W-1:0] U_BASE = ADDR_W'(IMAGE_WIDTH * IMAGE_HEIGHT / 2);
	localparam logic [ADDR_W-1:0] V_BASE =
		ADDR_W'(IMAGE_WIDTH * IMAGE_HEIGHT / 2 + IMAGE_WIDTH * IMAGE_HEIGHT / 4);
	localparam logic [2:0] LAST_SLOT = 3'(SLOT_CYCLES - 1);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_LEAD_IN = 3'd1;
	localparam logic [2:0] S_PAIR = 3'd2;
	localparam logic [2:0] S_LEAD_OUT = 3'd3;
	localparam logic [2:0] S_DONE = 3'd4;

	logic [2:0] state, slot;
	logic [ADDR_W-1:0] pair, row, row_base, rgb_ptr;
	logic [ADDR_W-1:0] ahead, chroma_idx;
	logic [PIXEL_W-1:0] held_lo, slot_byte;
	logic in_lead, in_pair, writing;

	assign in_lead = state == S_LEAD_IN;
	assign in_pair = state == S_PAIR;
	assign finish = state == S_DONE;

	// three samples ahead, clamped to the last one of the row
	assign ahead = (pair + ADDR_W'(3) > LAST_PAIR) ? LAST_PAIR : pair + ADDR_W'(3);
	assign chroma_idx = row_base + ahead;

	assign writing = slot >= 3'd3 && ((in_pair && pair != '0) || state == S_LEAD_OUT);
	assign sram_we_n = !writing;

	always_comb begin
		sram_address = row_base; // idle reads stay in the Y segment
		if (writing) begin
			sram_address = RGB_BASE + rgb_ptr;
		end else if (in_lead) begin
			// width a multiple of 4 keeps each chroma row word aligned
			sram_address = (slot[0] ? V_BASE : U_BASE) + (row_base >> 1) + ADDR_W'(slot[1]);
		end else if (in_pair && slot == 3'd0) begin
			sram_address = row_base + pair;
		end else if (in_pair && slot < 3'd3) begin
			sram_address = (slot[1] ? V_BASE : U_BASE) + (chroma_idx >> 1);
		end
	end

	always_comb begin
		case (slot)
			3'd3: sram_write_data.bytes = {r_even, g_even};
			3'd4: sram_write_data.bytes = {b_even, r_odd};
			default: sram_write_data.bytes = {g_odd, b_odd};
		endcase
	end

	assign slot_byte = (in_pair && chroma_idx[0]) ? sram_read_data.bytes[0] :
		sram_read_data.bytes[1];
	assign u_sample = (in_lead && slot == 3'd3) ? held_lo : slot_byte; // sample 1 from word 0
	assign v_sample = (in_lead && slot == 3'd4) ? held_lo : slot_byte;

	assign u_fill = in_lead && slot == 3'd2;
	assign v_fill = in_lead && slot == 3'd3;
	assign u_shift = (in_lead && (slot == 3'd3 || slot == 3'd4)) || (in_pair && slot == 3'd3);
	assign v_shift = (in_lead && (slot == 3'd4 || slot == LAST_SLOT)) ||
		(in_pair && slot == 3'd4);
	assign pair_valid = in_pair && slot == LAST_SLOT;

	always_ff @(posedge Clock_50) begin
		held_lo <= sram_read_data.bytes[0];
		if (in_pair && slot == 3'd2) begin
			y_pair <= sram_read_data;
		end
	end

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			slot <= '0;
			pair <= '0;
			row <= '0;
			row_base <= '0;
			rgb_ptr <= '0;
		end else begin
			if (state == S_IDLE || state == S_DONE || slot == LAST_SLOT) begin
				slot <= '0;
			end else begin
				slot <= slot + 3'd1;
			end
			if (writing) begin
				rgb_ptr <= rgb_ptr + ADDR_W'(1);
			end
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_LEAD_IN;
						pair <= '0;
						row <= '0;
						row_base <= '0;
						rgb_ptr <= '0;
					end
				end
				S_LEAD_IN: begin
					if (slot == LAST_SLOT) begin
						state <= S_PAIR;
						pair <= '0;
					end
				end
				S_PAIR: begin
					if (slot == LAST_SLOT) begin
						if (pair == LAST_PAIR) begin
							state <= S_LEAD_OUT;
						end else begin
							pair <= pair + ADDR_W'(1);
						end
					end
				end
				S_LEAD_OUT: begin
					if (slot == LAST_SLOT && row == LAST_ROW) begin
						state <= S_DONE;
					end else if (slot == LAST_SLOT) begin
						state <= S_LEAD_IN;
						row <= row + ADDR_W'(1);
						row_base <= row_base + HALF_W;
					end
				end
				default: state <= S_IDLE; // done and unused codes
			endcase
		end
	end

	assert property (@(posedge Clock_50) disable iff (!Resetn)
		!sram_we_n |-> sram_address >= RGB_BASE)
		else $error("write below the RGB segment");

	// V must have been shifted the cycle before the converter samples it
	assert property (@(posedge Clock_50) disable iff (!Resetn)
		pair_valid |-> slot == LAST_SLOT && $past(v_shift))
		else $error("pair_valid outside slot cycle 5");

endmodule

//--- rtl/csc_top.sv
`timescale 1ns/10ps

module csc_top #(
	parameter int IMAGE_WIDTH = 320,
	parameter int IMAGE_HEIGHT = 240
) (
	input logic Clock_50,
	input logic Resetn,
	input logic start,
	input csc_pkg::sram_word_u sram_read_data,
	output logic finish,
	output logic [csc_pkg::ADDR_W-1:0] sram_address,
	output logic sram_we_n,
	output csc_pkg::sram_word_u sram_write_data
);
	import csc_pkg::*;

	logic [PIXEL_W-1:0] u_sample, v_sample;
	logic u_fill, u_shift, v_fill, v_shift;
	logic pair_valid;
	sram_word_u y_pair;
	logic [PIXEL_W-1:0] u_even, u_odd, v_even, v_odd;
	logic [PIXEL_W-1:0] r_even, g_even, b_even, r_odd, g_odd, b_odd;

	csc_sequencer #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT)
	) i_sequencer (
		.Clock_50(Clock_50),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.r_even(r_even),
		.g_even(g_even),
		.b_even(b_even),
		.r_odd(r_odd),
		.g_odd(g_odd),
		.b_odd(b_odd),
		.finish(finish),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n),
		.sram_write_data(sram_write_data),
		.u_sample(u_sample),
		.v_sample(v_sample),
		.u_fill(u_fill),
		.u_shift(u_shift),
		.v_fill(v_fill),
		.v_shift(v_shift),
		.pair_valid(pair_valid),
		.y_pair(y_pair)
	);

	chroma_fir u_fir (
		.Clock_50(Clock_50),
		.Resetn(Resetn),
		.sample(u_sample),
		.fill(u_fill),
		.shift(u_shift),
		.even_out(u_even),
		.odd_out(u_odd)
	);

	chroma_fir v_fir (
		.Clock_50(Clock_50),
		.Resetn(Resetn),
		.sample(v_sample),
		.fill(v_fill),
		.shift(v_shift),
		.even_out(v_even),
		.odd_out(v_odd)
	);

	yuv_to_rgb i_convert (
		.Clock_50(Clock_50),
		.Resetn(Resetn),
		.pair_valid(pair_valid),
		.y_pair(y_pair),
		.u_even(u_even),
		.u_odd(u_odd),
		.v_even(v_even),
		.v_odd(v_odd),
		.r_even(r_even),
		.g_even(g_even),
		.b_even(b_even),
		.r_odd(r_odd),
		.g_odd(g_odd),
		.b_odd(b_odd)
	);

endmodule

//--- test/tb_csc.sv
`timescale 1ns/10ps

module tb_csc;
	import csc_pkg::*;

	localparam int IMAGE_WIDTH = 16;
	localparam int IMAGE_HEIGHT = 3;
	localparam int HALF_W = IMAGE_WIDTH / 2;
	localparam int U_BASE = IMAGE_WIDTH * IMAGE_HEIGHT / 2;
	localparam int V_BASE = U_BASE + IMAGE_WIDTH * IMAGE_HEIGHT / 4;
	localparam int YUV_END = V_BASE + IMAGE_WIDTH * IMAGE_HEIGHT / 4;
	localparam int RGB_WORDS = 3 * IMAGE_WIDTH * IMAGE_HEIGHT / 2;
	localparam int FRAMES = 4;
	localparam int CLK_PERIOD = 40;
	localparam int WATCHDOG_NS = 2 * FRAMES * IMAGE_HEIGHT * (HALF_W + 2) * 6 * CLK_PERIOD;

	logic Clock_50 = 1'b0;
	logic Resetn = 1'b0;
	logic start = 1'b0;
	logic finish, sram_we_n;
	logic [ADDR_W-1:0] sram_address;
	sram_word_u sram_read_data, sram_write_data;
	int seed = 3;
	int mismatch_errors = 0;
	int other_errors = 0;
	int finish_count = 0;

	csc_top #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT)
	) i_csc_top (
		.Clock_50(Clock_50),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.finish(finish),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n),
		.sram_write_data(sram_write_data)
	);

	tb_sram i_sram (
		.Clock_50(Clock_50),
		.address(sram_address),
		.we_n(sram_we_n),
		.write_data(sram_write_data),
		.read_data(sram_read_data)
	);

	always #(CLK_PERIOD / 2) Clock_50 = ~Clock_50;

	function automatic logic [7:0] saturate(input int value);
		if (value < 0) begin
			return 8'd0;
		end
		if (value > 255) begin
			return 8'd255;
		end
		return value[7:0];
	endfunction

	// edge samples repeat outside the row
	function automatic int chroma_at(input int base, input int row, input int k);
		int idx;
		sram_word_u word;
		idx = row * HALF_W + ((k < 0) ? 0 : (k > HALF_W - 1) ? HALF_W - 1 : k);
		word.raw = i_sram.mem[base + idx / 2];
		return (idx % 2 == 0) ? word.bytes[1] : word.bytes[0];
	endfunction

	function automatic int upsample_odd(input int base, input int row, input int k);
		int acc;
		acc = 21 * (chroma_at(base, row, k - 2) + chroma_at(base, row, k + 3))
			- 52 * (chroma_at(base, row, k - 1) + chroma_at(base, row, k + 2))
			+ 159 * (chroma_at(base, row, k) + chroma_at(base, row, k + 1)) + 128;
		return saturate(acc >>> 8);
	endfunction

	function automatic logic [23:0] convert_pixel(input int y, input int u, input int v);
		int luma;
		luma = 76284 * (y - 16);
		return {saturate((luma + 104595 * (v - 128)) >>> 16),
			saturate((luma - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16),
			saturate((luma + 132251 * (u - 128)) >>> 16)};
	endfunction

	task automatic fill_random();
		for (int a = 0; a < YUV_END; a++) begin
			i_sram.preload(a, 16'($random(seed)));
		end
	endtask

	task automatic set_chroma(input int base, input int row, input int k, input logic [7:0] value);
		int idx;
		sram_word_u word;
		idx = row * HALF_W + k;
		word.raw = i_sram.mem[base + idx / 2];
		if (idx % 2 == 0) begin
			word.bytes[1] = value;
		end else begin
			word.bytes[0] = value;
		end
		i_sram.preload(base + idx / 2, word.raw);
	endtask

	task automatic fill_edges();
		fill_random();
		for (int r = 0; r < IMAGE_HEIGHT; r++) begin
			set_chroma(U_BASE, r, 0, 8'h00);
			set_chroma(U_BASE, r, HALF_W - 1, 8'hff);
			set_chroma(V_BASE, r, 0, 8'hff);
			set_chroma(V_BASE, r, HALF_W - 1, 8'h00);
		end
	endtask

	task automatic fill_clip();
		logic [1:0] bits;
		for (int a = 0; a < YUV_END; a++) begin
			bits = 2'($random(seed));
			i_sram.preload(a, (a < U_BASE) ? 16'hffff : {{8{bits[1]}}, {8{bits[0]}}});
		end
	endtask

	task automatic check_frame(input string name);
		sram_word_u y_word;
		logic [47:0] pair_rgb;
		logic [15:0] expected;
		int addr;
		assert (i_sram.write_total == RGB_WORDS) else begin
			other_errors++;
			$display("%s: %0d RGB writes instead of %0d", name, i_sram.write_total, RGB_WORDS);
		end
		for (int r = 0; r < IMAGE_HEIGHT; r++) begin
			for (int p = 0; p < HALF_W; p++) begin
				y_word.raw = i_sram.mem[r * HALF_W + p];
				pair_rgb = {convert_pixel(y_word.bytes[1], chroma_at(U_BASE, r, p),
					chroma_at(V_BASE, r, p)), convert_pixel(y_word.bytes[0],
					upsample_odd(U_BASE, r, p), upsample_odd(V_BASE, r, p))};
				for (int w = 0; w < 3; w++) begin
					addr = RGB_BASE + 3 * (r * HALF_W + p) + w;
					expected = pair_rgb[47 - 16 * w -: 16];
					assert (i_sram.write_hits[addr] == 1) else begin
						other_errors++;
						$display("%s: RGB address %0d written %0d times", name, addr,
							i_sram.write_hits[addr]);
					end
					assert (i_sram.mem[addr] === expected) else begin
						mismatch_errors++;
						$display("Mismatch %s: address %0d expected %h actual %h", name, addr,
							expected, i_sram.mem[addr]);
					end
				end
			end
		end
	endtask

	task automatic run_frame(input string name, input bit mid_start);
		i_sram.clear_log();
		finish_count = 0;
		@(posedge Clock_50);
		#2 start = 1'b1;
		@(posedge Clock_50);
		#2 start = 1'b0;
		if (mid_start) begin
			repeat (40) @(posedge Clock_50);
			#2 start = 1'b1; // busy, so this one is ignored
			@(posedge Clock_50);
			#2 start = 1'b0;
		end
		@(negedge Clock_50);
		while (!finish) begin
			@(negedge Clock_50);
		end
		repeat (4) @(negedge Clock_50);
		assert (finish_count == 1) else begin
			other_errors++;
			$display("%s: %0d finish strobes instead of one", name, finish_count);
		end
		check_frame(name);
	endtask

	// bus ranges and finish order
	always @(negedge Clock_50) begin
		if (Resetn) begin
			if (!sram_we_n) begin
				assert (sram_address >= RGB_BASE && sram_address < RGB_BASE + RGB_WORDS) else begin
					other_errors++;
					$display("write to address %0d outside the RGB segment", sram_address);
				end
			end else begin
				assert (sram_address < YUV_END) else begin
					other_errors++;
					$display("read from address %0d outside the YUV segments", sram_address);
				end
			end
			if (finish) begin
				finish_count++;
				assert (i_sram.write_total == RGB_WORDS) else begin
					other_errors++;
					$display("finish came before all RGB words were written");
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all frames finished");
		$display("Errors found");
		$finish;
	end

	initial begin
		i_sram.clear_log();
		repeat (2) @(posedge Clock_50);
		#2 Resetn = 1'b1;
		repeat (6) begin
			@(negedge Clock_50);
			assert (sram_we_n === 1'b1 && finish === 1'b0) else begin
				other_errors++;
				$display("write strobe or finish active before start");
			end
		end
		assert (i_sram.write_total == 0) else begin
			other_errors++;
			$display("SRAM written before start");
		end
		fill_random();
		run_frame("random_frame", 1'b1);
		fill_edges();
		run_frame("edge_frame", 1'b0);
		fill_clip();
		run_frame("clip_frame", 1'b0);
		fill_random();
		run_frame("restart_frame", 1'b0);
		$display("mismatches: %0d, other errors: %0d", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- test/tb_sram.sv
`timescale 1ns/10ps

module tb_sram (
	input logic Clock_50,
	input logic [csc_pkg::ADDR_W-1:0] address,
	input logic we_n,
	input csc_pkg::sram_word_u write_data,
	output csc_pkg::sram_word_u read_data
);
	import csc_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	logic [WORD_W-1:0] mem [DEPTH];
	logic [WORD_W-1:0] read_stage = '0;
	logic [WORD_W-1:0] read_q = '0;
	int write_hits [DEPTH];
	int write_total;

	assign read_data = read_q;

	// data shows up on the second edge after the address
	always @(posedge Clock_50) begin
		read_q <= read_stage;
		read_stage = mem[address];
		if (!we_n) begin
			mem[address] = write_data.raw;
			write_hits[address] = write_hits[address] + 1;
			write_total = write_total + 1;
		end
	end

	task automatic preload(input int addr, input logic [WORD_W-1:0] data);
		mem[addr] = data;
	endtask

	task automatic clear_log();
		for (int i = 0; i < DEPTH; i++) begin
			write_hits[i] = 0;
		end
		write_total = 0;
	endtask

endmodule

//--- upsample/chroma_fir.sv
`timescale 1ns/10ps

module chroma_fir (
	input logic Clock_50,
	input logic Resetn,
	input logic [csc_pkg::PIXEL_W-1:0] sample,
	input logic fill,
	input logic shift,
	output logic [csc_pkg::PIXEL_W-1:0] even_out,
	output logic [csc_pkg::PIXEL_W-1:0] odd_out
);
	import csc_pkg::*;

	localparam int TAPS = 6;

	logic [PIXEL_W-1:0] taps [TAPS];
	logic [PIXEL_W-1:0] next_taps [TAPS];
	logic signed [ACC_W-1:0] outer_sum, inner_sum, centre_sum, acc;

	// tap 0 is the oldest sample, tap 5 the newest
	always_comb begin
		next_taps = taps;
		if (fill) begin
			for (int i = 0; i < TAPS; i++) begin
				next_taps[i] = sample;
			end
		end else if (shift) begin
			for (int i = 0; i < TAPS - 1; i++) begin
				next_taps[i] = taps[i + 1];
			end
			next_taps[TAPS - 1] = sample;
		end
	end

	assign outer_sum = ACC_W'(next_taps[0]) + ACC_W'(next_taps[5]);
	assign inner_sum = ACC_W'(next_taps[1]) + ACC_W'(next_taps[4]);
	assign centre_sum = ACC_W'(next_taps[2]) + ACC_W'(next_taps[3]);
	assign acc = FIR_C0 * outer_sum - FIR_C1 * inner_sum + FIR_C2 * centre_sum + FIR_ROUND;

	always_ff @(posedge Clock_50) begin
		if (fill || shift) begin
			taps <= next_taps;
			even_out <= next_taps[2]; // centre sample passes through
			odd_out <= clip_pixel(acc >>> FIR_SHIFT);
		end
	end

	assert property (@(posedge Clock_50) disable iff (!Resetn) !(fill && shift))
		else $error("fill and shift together");

endmodule
